/* common/tcu_cfg.svh */
// tensor core tile configuration
// lane count, operand row length and pipeline stage depths
`ifndef TCU_CFG_SVH
`define TCU_CFG_SVH

// lanes per tile, one result word each
`define TCU_LANES   4

// 32-bit words in every A row and B column
`define TCU_N       2

`define TCU_MUL_LAT 2
`define TCU_ACC_LAT 2

`endif

/* common/tcu_pkg.sv */
// tensor core shared types
// integer format codes, the sub-word operand view and operand rows
`include "tcu_cfg.svh"

package tcu_pkg;

    // top bit marks an integer format
    typedef enum logic [3:0] {
        TCU_I8 = 4'd8,
        TCU_U8 = 4'd9,
        TCU_I4 = 4'd10,
        TCU_U4 = 4'd11
    } tcu_fmt_e;

    // one operand word seen as bytes or as nibbles
    typedef union packed {
        logic [3:0][7:0] b;
        logic [7:0][3:0] n;
    } tcu_word_u;

    // one A row or one B column
    typedef logic [`TCU_N-1:0][31:0] tcu_row_t;

endpackage

/* common/tcu_issue_if.sv */
// issue bus from dispatch to the lane array
// valid is a single-cycle pulse, payload held stable with it
`timescale 1ns/1ps
`include "tcu_cfg.svh"

interface tcu_issue_if (
    input logic clk
);
    import tcu_pkg::*;

    logic                          valid;
    tcu_fmt_e                      fmt;
    tcu_row_t                      a_row;
    tcu_row_t [`TCU_LANES-1:0]     b_cols;
    logic [`TCU_LANES-1:0][31:0]   c_vals;

    modport issue (
        output valid,
        output fmt,
        output a_row,
        output b_cols,
        output c_vals
    );

    // b column and addend reach each lane by plain ports
    modport lane (
        input clk,
        input valid,
        input fmt,
        input a_row
    );

endinterface

/* fedp/tcu_pipe_reg.sv */
// pipeline delay line
// shifts a data word and its valid bit through DEPTH registers
`timescale 1ns/1ps

module tcu_pipe_reg #(
    parameter int DATAW = 32,
    parameter int DEPTH = 1
) (
    input  logic             clk,
    input  logic             reset,
    input  logic             valid_in,
    input  logic [DATAW-1:0] data_in,
    output logic             valid_out,
    output logic [DATAW-1:0] data_out
);

    if (DEPTH == 0) begin : g_pass
        assign valid_out = valid_in;
        assign data_out  = data_in;
    end else begin : g_regs
        logic [DEPTH-1:0]            vld_q;
        logic [DEPTH-1:0][DATAW-1:0] data_q;

        always_ff @(posedge clk) begin
            if (reset) begin
                vld_q <= '0;
            end else begin
                vld_q[0] <= valid_in;
                for (int i = 1; i < DEPTH; i++) begin
                    vld_q[i] <= vld_q[i-1];
                end
            end
        end

        always_ff @(posedge clk) begin
            data_q[0] <= data_in;
            for (int i = 1; i < DEPTH; i++) begin
                data_q[i] <= data_q[i-1];
            end
        end

        assign valid_out = vld_q[DEPTH-1];
        assign data_out  = data_q[DEPTH-1];
    end

endmodule

/* fedp/tcu_fedp.sv */
// fused dot product lane
// multiplies sub-words of the A row and this lane's B column, sums
// the products per word, then adds all partials and the addend
// modulo 2^32, two multiply stages and two accumulate stages
`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_fedp (
    input  logic             clk,
    input  logic             reset,
    tcu_issue_if.lane        issue,
    input  tcu_pkg::tcu_row_t b_col,
    input  logic [31:0]      c_val,
    output logic [31:0]      d_val,
    output logic             d_valid
);
    import tcu_pkg::*;

    localparam int PARTW = 32 * `TCU_N;

    logic [`TCU_N-1:0][31:0] part;
    logic [`TCU_N-1:0][31:0] part_d;
    logic                    part_vld;
    logic [31:0]             c_d;
    logic                    c_vld;
    logic [31:0]             acc;

    // sub-word products, one 32-bit partial per word
    always_comb begin
        tcu_word_u          a_w;
        tcu_word_u          b_w;
        logic signed [31:0] sp;
        logic [31:0]        up;
        logic [31:0]        sum;
        for (int i = 0; i < `TCU_N; i++) begin
            a_w = issue.a_row[i];
            b_w = b_col[i];
            sum = '0;
            sp  = '0;
            up  = '0;
            case (issue.fmt)
                TCU_I8: begin
                    for (int j = 0; j < 4; j++) begin
                        sp  = $signed(a_w.b[j]) * $signed(b_w.b[j]);
                        sum = sum + sp;
                    end
                end
                TCU_U8: begin
                    for (int j = 0; j < 4; j++) begin
                        up  = a_w.b[j] * b_w.b[j];
                        sum = sum + up;
                    end
                end
                TCU_I4: begin
                    for (int j = 0; j < 8; j++) begin
                        sp  = $signed(a_w.n[j]) * $signed(b_w.n[j]);
                        sum = sum + sp;
                    end
                end
                TCU_U4: begin
                    for (int j = 0; j < 8; j++) begin
                        up  = a_w.n[j] * b_w.n[j];
                        sum = sum + up;
                    end
                end
                default: sum = '0;
            endcase
            part[i] = sum;
        end
    end

    tcu_pipe_reg #(
        .DATAW (PARTW),
        .DEPTH (`TCU_MUL_LAT)
    ) pipe_mul (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (issue.valid),
        .data_in   (part),
        .valid_out (part_vld),
        .data_out  (part_d)
    );

    // addend rides alongside the products
    tcu_pipe_reg #(
        .DATAW (32),
        .DEPTH (`TCU_MUL_LAT)
    ) pipe_c (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (issue.valid),
        .data_in   (c_val),
        .valid_out (c_vld),
        .data_out  (c_d)
    );

    // wraps modulo 2^32
    always_comb begin
        acc = c_d;
        for (int i = 0; i < `TCU_N; i++) begin
            acc = acc + part_d[i];
        end
    end

    tcu_pipe_reg #(
        .DATAW (32),
        .DEPTH (`TCU_ACC_LAT)
    ) pipe_acc (
        .clk       (clk),
        .reset     (reset),
        .valid_in  (part_vld & c_vld),
        .data_in   (acc),
        .valid_out (d_valid),
        .data_out  (d_val)
    );

    // dispatch filters illegal codes before they reach a lane
    a_fmt_legal: assert property (@(posedge clk) disable iff (reset)
        issue.valid |-> issue.fmt inside {TCU_I8, TCU_U8, TCU_I4, TCU_U4});

endmodule

/* source/tcu_dispatch.sv */
// request side of the tile handshake
// catches the rising edge of req, checks the format code and either
// issues the operands to all lanes or reports an error to collect
`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_dispatch (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req,
    input  tcu_pkg::tcu_fmt_e                     fmt,
    input  tcu_pkg::tcu_row_t                     a_row,
    input  tcu_pkg::tcu_row_t [`TCU_LANES-1:0]    b_cols,
    input  logic [`TCU_LANES-1:0][31:0]           c_vals,
    tcu_issue_if.issue                            issue,
    output logic                                  err_pulse
);
    import tcu_pkg::*;

    logic req_q;
    logic req_qq;
    logic req_rise;
    logic fmt_ok;

    // one issue per req high phase
    assign req_rise = req_q & ~req_qq;

    // integer codes only
    assign fmt_ok = fmt inside {TCU_I8, TCU_U8, TCU_I4, TCU_U4};

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q       <= 1'b0;
            req_qq      <= 1'b0;
            issue.valid <= 1'b0;
            err_pulse   <= 1'b0;
        end else begin
            req_q       <= req;
            req_qq      <= req_q;
            issue.valid <= req_rise & fmt_ok;
            err_pulse   <= req_rise & ~fmt_ok;
        end
    end

    // operands are held by the requester while req is high
    always_ff @(posedge clk) begin
        if (req_rise && fmt_ok) begin
            issue.fmt    <= fmt;
            issue.a_row  <= a_row;
            issue.b_cols <= b_cols;
            issue.c_vals <= c_vals;
        end
    end

endmodule

/* source/tcu_collect.sv */
// response side of the tile handshake
// latches the lane results or an error, raises ack and drops it
// again once req has been seen low
`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_collect (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [`TCU_LANES-1:0][31:0]   d_val,
    input  logic [`TCU_LANES-1:0]         d_valid,
    input  logic                          err_pulse,
    input  logic                          req,
    output logic [`TCU_LANES-1:0][31:0]   d_vals,
    output logic                          err,
    output logic                          ack
);

    logic req_q;
    logic all_valid;

    // lanes run in lockstep
    assign all_valid = &d_valid;

    always_ff @(posedge clk) begin
        if (reset) begin
            req_q <= 1'b0;
            ack   <= 1'b0;
            err   <= 1'b0;
        end else begin
            req_q <= req;
            if (all_valid) begin
                ack <= 1'b1;
                err <= 1'b0;
            end else if (err_pulse) begin
                ack <= 1'b1;
                err <= 1'b1;
            end else if (ack && !req_q) begin
                ack <= 1'b0;
                err <= 1'b0;
            end
        end
    end

    // refused requests answer with zeros
    always_ff @(posedge clk) begin
        if (all_valid) begin
            d_vals <= d_val;
        end else if (err_pulse) begin
            d_vals <= '0;
        end
    end

    a_lanes_lockstep: assert property (@(posedge clk) disable iff (reset)
        (d_valid == '0) || all_valid);

    // the handshake keeps a second result out while ack is up
    a_no_overlap: assert property (@(posedge clk) disable iff (reset)
        ack |-> (d_valid == '0) && !err_pulse);

endmodule

/* source/tcu_top.sv */
// integer tensor core dot product tile
// dispatch feeds an array of identical dot product lanes over the
// issue bus, collect gathers their results for the req/ack handshake
`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_top (
    input  logic                                  clk,
    input  logic                                  reset,
    input  logic                                  req,
    input  logic [3:0]                            fmt,
    input  tcu_pkg::tcu_row_t                     a_row,
    input  tcu_pkg::tcu_row_t [`TCU_LANES-1:0]    b_cols,
    input  logic [`TCU_LANES-1:0][31:0]           c_vals,
    output logic                                  ack,
    output logic                                  err,
    output logic [`TCU_LANES-1:0][31:0]           d_vals
);
    import tcu_pkg::*;

    logic [`TCU_LANES-1:0][31:0] lane_d_val;
    logic [`TCU_LANES-1:0]       lane_d_valid;
    logic                        err_pulse;

    tcu_issue_if issue_bus (
        .clk (clk)
    );

    tcu_dispatch u_dispatch (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .fmt       (tcu_fmt_e'(fmt)),
        .a_row     (a_row),
        .b_cols    (b_cols),
        .c_vals    (c_vals),
        .issue     (issue_bus.issue),
        .err_pulse (err_pulse)
    );

    for (genvar l = 0; l < `TCU_LANES; l++) begin : g_lane
        tcu_fedp u_fedp (
            .clk     (clk),
            .reset   (reset),
            .issue   (issue_bus.lane),
            .b_col   (issue_bus.b_cols[l]),
            .c_val   (issue_bus.c_vals[l]),
            .d_val   (lane_d_val[l]),
            .d_valid (lane_d_valid[l])
        );
    end

    tcu_collect u_collect (
        .clk       (clk),
        .reset     (reset),
        .d_val     (lane_d_val),
        .d_valid   (lane_d_valid),
        .err_pulse (err_pulse),
        .req       (req),
        .d_vals    (d_vals),
        .err       (err),
        .ack       (ack)
    );

endmodule

/* sim/tcu_checker.sv */
// tensor core tile response checker
// samples the operands when req rises, models the integer dot product
// and compares every ack against it, also watches the handshake order
`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_checker (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req,
    input  logic [3:0]                         fmt,
    input  tcu_pkg::tcu_row_t                  a_row,
    input  tcu_pkg::tcu_row_t [`TCU_LANES-1:0] b_cols,
    input  logic [`TCU_LANES-1:0][31:0]        c_vals,
    input  logic                               ack,
    input  logic                               err,
    input  logic [`TCU_LANES-1:0][31:0]        d_vals,
    output int                                 tests,
    output int                                 errors
);
    import tcu_pkg::*;

    // dispatch, multiply, accumulate, collect
    localparam int LAT_OK  = 2 + `TCU_MUL_LAT + `TCU_ACC_LAT;
    localparam int LAT_ERR = 2;

    logic                               req_q;
    logic                               ack_q;
    logic                               pending;
    int                                 cycle;
    int                                 start;
    logic [3:0]                         s_fmt;
    tcu_row_t                           s_a;
    tcu_row_t [`TCU_LANES-1:0]          s_b;
    logic [`TCU_LANES-1:0][31:0]        s_c;
    logic                               h_err;
    logic [`TCU_LANES-1:0][31:0]        h_d;

    // addend plus every sub-word product, wrapping at 32 bits
    function automatic logic [31:0] dot_model(input logic [3:0] f, input tcu_row_t a,
                                              input tcu_row_t b, input logic [31:0] c);
        tcu_word_u   aw;
        tcu_word_u   bw;
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] sum;
        sum = c;
        for (int i = 0; i < `TCU_N; i++) begin
            aw = a[i];
            bw = b[i];
            if (f == TCU_I8 || f == TCU_U8) begin
                for (int j = 0; j < 4; j++) begin
                    x = {24'd0, aw.b[j]};
                    y = {24'd0, bw.b[j]};
                    if (f == TCU_I8) begin
                        x = {{24{aw.b[j][7]}}, aw.b[j]};
                        y = {{24{bw.b[j][7]}}, bw.b[j]};
                    end
                    sum = sum + x * y;
                end
            end else begin
                for (int j = 0; j < 8; j++) begin
                    x = {28'd0, aw.n[j]};
                    y = {28'd0, bw.n[j]};
                    if (f == TCU_I4) begin
                        x = {{28{aw.n[j][3]}}, aw.n[j]};
                        y = {{28{bw.n[j][3]}}, bw.n[j]};
                    end
                    sum = sum + x * y;
                end
            end
        end
        return sum;
    endfunction

    task automatic check_response();
        logic        legal;
        logic        exp_err;
        logic [31:0] exp_d;
        int          lat;
        int          bad;
        legal   = s_fmt inside {TCU_I8, TCU_U8, TCU_I4, TCU_U4};
        exp_err = ~legal;
        // ack is seen one edge after the edge that sets it
        lat = cycle - 1 - start;
        bad = 0;
        if (lat != (legal ? LAT_OK : LAT_ERR)) begin
            $display("ERROR at %0t: ack latency expected %0d got %0d",
                     $time, legal ? LAT_OK : LAT_ERR, lat);
            bad++;
        end
        if (err !== exp_err) begin
            $display("ERROR at %0t: err flag expected %b got %b", $time, exp_err, err);
            bad++;
        end
        for (int l = 0; l < `TCU_LANES; l++) begin
            exp_d = legal ? dot_model(s_fmt, s_a, s_b[l], s_c[l]) : 32'd0;
            if (d_vals[l] !== exp_d) begin
                $display("ERROR at %0t: lane %0d expected %h got %h",
                         $time, l, exp_d, d_vals[l]);
                bad++;
            end
        end
        tests++;
        errors += bad;
        $display("test %0d format %0d latency %0d: %s",
                 tests, s_fmt, lat, (bad == 0) ? "ok" : "mismatch");
    endtask

    always @(posedge clk) begin
        if (reset) begin
            req_q   = 1'b0;
            ack_q   = 1'b0;
            pending = 1'b0;
            cycle   = 0;
            tests   = 0;
            errors  = 0;
        end else begin
            cycle = cycle + 1;
            if (req && !req_q) begin
                if (pending || ack) begin
                    $display("handshake fault at %0t: req raised before the last ack ended",
                             $time);
                    errors++;
                end
                pending = 1'b1;
                start   = cycle;
                s_fmt   = fmt;
                s_a     = a_row;
                s_b     = b_cols;
                s_c     = c_vals;
            end
            if (ack && !ack_q) begin
                if (!pending) begin
                    $display("handshake fault at %0t: ack rose with no request pending", $time);
                    errors++;
                end else begin
                    check_response();
                end
                pending = 1'b0;
                h_err   = err;
                h_d     = d_vals;
            end else if (ack && ack_q) begin
                if (err !== h_err || d_vals !== h_d) begin
                    $display("handshake fault at %0t: results changed while ack was high",
                             $time);
                    errors++;
                end
            end
            if (!ack && ack_q && req) begin
                $display("handshake fault at %0t: ack dropped while req was still high", $time);
                errors++;
            end
            req_q = req;
            ack_q = ack;
        end
    end

endmodule

/* sim/tcu_tb.sv */
// tensor core tile testbench
// drives seeded random transactions through the req/ack handshake,
// the checker compares every response with its own model
`timescale 1ns/1ps
`include "tcu_cfg.svh"

module tcu_tb;
    import tcu_pkg::*;

    localparam int ACK_TIMEOUT = 50;

    logic                          clk;
    logic                          reset;
    logic                          req;
    logic [3:0]                    fmt;
    tcu_row_t                      a_row;
    tcu_row_t [`TCU_LANES-1:0]     b_cols;
    logic [`TCU_LANES-1:0][31:0]   c_vals;
    logic                          ack;
    logic                          err;
    logic [`TCU_LANES-1:0][31:0]   d_vals;
    logic [`TCU_LANES-1:0][31:0]   d_last;
    logic [`TCU_LANES-1:0][31:0]   d_first;
    integer                        seed;
    int                            tests;
    int                            errors;
    int                            timeouts;
    int                            sent;
    int                            differ;

    tcu_top UUT (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .fmt    (fmt),
        .a_row  (a_row),
        .b_cols (b_cols),
        .c_vals (c_vals),
        .ack    (ack),
        .err    (err),
        .d_vals (d_vals)
    );

    tcu_checker chk (
        .clk    (clk),
        .reset  (reset),
        .req    (req),
        .fmt    (fmt),
        .a_row  (a_row),
        .b_cols (b_cols),
        .c_vals (c_vals),
        .ack    (ack),
        .err    (err),
        .d_vals (d_vals),
        .tests  (tests),
        .errors (errors)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic randomize_operands();
        for (int i = 0; i < `TCU_N; i++) begin
            a_row[i] = $random(seed);
        end
        for (int l = 0; l < `TCU_LANES; l++) begin
            for (int i = 0; i < `TCU_N; i++) begin
                b_cols[l][i] = $random(seed);
            end
            c_vals[l] = $random(seed);
        end
    endtask

    // corner operands for the unsigned byte format
    task automatic force_extremes(input int kind);
        for (int i = 0; i < `TCU_N; i++) begin
            case (kind)
                0: a_row[i] = '1;
                1: a_row[i] = 32'hff00ff00;
                2: a_row[i] = 32'h80ff7f01;
                default: a_row[i] = '1;
            endcase
        end
        for (int l = 0; l < `TCU_LANES; l++) begin
            for (int i = 0; i < `TCU_N; i++) begin
                case (kind)
                    0: b_cols[l][i] = '1;
                    1: b_cols[l][i] = '1;
                    2: b_cols[l][i] = 32'hff01ff80;
                    default: b_cols[l][i] = b_cols[l][i] | 32'h80808080;
                endcase
            end
            case (kind)
                0: c_vals[l] = '1;
                1: c_vals[l] = 32'hfffffff0;
                2: c_vals[l] = 32'hffffffff - l;
                default: c_vals[l] = c_vals[l] | 32'hf0000000;
            endcase
        end
    endtask

    // one full req/ack exchange on the operands already driven
    task automatic run_txn(input logic [3:0] code);
        int cnt;
        @(negedge clk);
        fmt = code;
        req = 1'b1;
        sent++;
        cnt = 0;
        while (ack !== 1'b1 && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack !== 1'b1) begin
            $display("timeout at %0t: no ack came for a request with format %0d", $time, code);
            timeouts++;
        end
        d_last = d_vals;
        @(negedge clk);
        req = 1'b0;
        cnt = 0;
        while (ack !== 1'b0 && cnt < ACK_TIMEOUT) begin
            @(negedge clk);
            cnt++;
        end
        if (ack !== 1'b0) begin
            $display("timeout at %0t: ack stayed high after req was dropped", $time);
            timeouts++;
        end
    endtask

    initial begin
        logic [3:0] code;
        logic [7:0] r;
        seed     = 32'h9ead;
        reset    = 1'b1;
        req      = 1'b0;
        fmt      = TCU_I8;
        a_row    = '0;
        b_cols   = '0;
        c_vals   = '0;
        timeouts = 0;
        sent     = 0;
        differ   = 0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        for (int t = 0; t < 40; t++) begin
            randomize_operands();
            run_txn(TCU_I8);
        end

        for (int t = 0; t < 12; t++) begin
            randomize_operands();
            force_extremes(t % 4);
            run_txn(TCU_U8);
        end

        // same words under both nibble formats
        for (int t = 0; t < 20; t++) begin
            randomize_operands();
            run_txn(TCU_I4);
            d_first = d_last;
            run_txn(TCU_U4);
            if (d_last != d_first) begin
                differ++;
            end
        end

        for (int t = 0; t < 30; t++) begin
            randomize_operands();
            r = $random(seed);
            if (r[0]) begin
                code = r[7:4];
                if (code inside {[4'd8:4'd11]}) begin
                    code = code ^ 4'b1000;
                end
            end else begin
                code = 4'd8 + r[2:1];
            end
            run_txn(code);
        end

        repeat (4) @(negedge clk);
        if (differ == 0) begin
            $display("signed and unsigned 4-bit runs never gave different results");
        end
        if (tests != sent) begin
            $display("not every request got exactly one ack");
        end
        $display("tests %0d of %0d requests, %0d errors, %0d timeouts",
                 tests, sent, errors, timeouts);
        if (errors == 0 && timeouts == 0 && tests == sent && differ != 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+common
common/tcu_pkg.sv
common/tcu_issue_if.sv
fedp/tcu_pipe_reg.sv
fedp/tcu_fedp.sv
source/tcu_dispatch.sv
source/tcu_collect.sv
source/tcu_top.sv
sim/tcu_checker.sv
sim/tcu_tb.sv
